// ==== verilog/mem_path_pkg.sv ====
`default_nettype none

package mem_path_pkg;

	// byte address, line requests keep the low offset bits at zero
	localparam int ADDR_WIDTH = 32;

	// one memory beat carries two 32-bit words
	localparam int BEAT_WIDTH = 64;

	// burst length on the physical port
	localparam int BEATS_PER_LINE = 4;

	// a line is exactly one full burst
	localparam int LINE_WIDTH = BEATS_PER_LINE * BEAT_WIDTH;

	// 32 bytes per line
	localparam int OFFSET_BITS = 5;

	// beat counter sized to the burst
	localparam int BEAT_CNT_BITS = $clog2(BEATS_PER_LINE);

	typedef logic [ADDR_WIDTH-1:0] addr_t;
	typedef logic [LINE_WIDTH-1:0] line_t;
	typedef logic [BEAT_WIDTH-1:0] beat_t;
	typedef logic [BEAT_CNT_BITS-1:0] beat_cnt_t;

	// index of the final beat of a burst
	localparam beat_cnt_t LAST_BEAT = beat_cnt_t'(BEATS_PER_LINE - 1);

	// request toward memory, strobes held until resp
	typedef struct packed {
		logic read;
		logic write;
		addr_t address;
		line_t wdata;
	} line_req_t;

	// answer back toward the caches
	// rdata only meaningful in the resp cycle of a read
	typedef struct packed {
		logic resp;
		line_t rdata;
	} line_rsp_t;

	// clear the line offset
	function automatic addr_t line_align(input addr_t address);
		return {address[ADDR_WIDTH-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
	endfunction

endpackage : mem_path_pkg

`default_nettype wire

// ==== verilog/line_arbiter.sv ====
`default_nettype none

module line_arbiter import mem_path_pkg::*; (
	input  wire logic      clk,
	input  wire logic      rst_n,
	// instruction cache, line reads only
	input  wire line_req_t icache_req,
	output line_rsp_t      icache_rsp,
	// data cache, line reads and writebacks
	input  wire line_req_t dcache_req,
	output line_rsp_t      dcache_rsp,
	// toward the eviction write buffer
	output line_req_t      arb_req,
	input  wire line_rsp_t arb_rsp
);

	// which cache currently owns the path
	typedef enum logic [1:0] {
		GRANT_IDLE   = 2'b00,
		GRANT_ICACHE = 2'b01,
		GRANT_DCACHE = 2'b10
	} grant_t;

	grant_t grant;

	logic icache_pending;
	logic dcache_pending;

	// icache write strobe is not part of the protocol
	assign icache_pending = icache_req.read;
	assign dcache_pending = dcache_req.read | dcache_req.write;

	// grant register
	// decided only from idle, released in the resp cycle
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			grant <= GRANT_IDLE;
		end else begin
			case (grant)
				GRANT_IDLE: begin
					// data side wins a tie
					if (dcache_pending) begin
						grant <= GRANT_DCACHE;
					end else if (icache_pending) begin
						grant <= GRANT_ICACHE;
					end
				end
				GRANT_ICACHE, GRANT_DCACHE: begin
					// back to idle, loser gets picked up next cycle
					if (arb_rsp.resp) begin
						grant <= GRANT_IDLE;
					end
				end
				default: begin
					grant <= GRANT_IDLE;
				end
			endcase
		end
	end

	// downstream request mux
	always_comb begin
		arb_req = '0;
		case (grant)
			GRANT_ICACHE: begin
				// read only, write and wdata stay zero
				arb_req.read    = icache_req.read;
				arb_req.address = icache_req.address;
			end
			GRANT_DCACHE: begin
				arb_req = dcache_req;
			end
			default: begin
				// nothing granted, bus looks idle downstream
				arb_req = '0;
			end
		endcase
	end

	// response steering
	// rdata fans out to both, resp only to the owner
	always_comb begin
		icache_rsp.rdata = arb_rsp.rdata;
		icache_rsp.resp  = arb_rsp.resp & (grant == GRANT_ICACHE);
		dcache_rsp.rdata = arb_rsp.rdata;
		dcache_rsp.resp  = arb_rsp.resp & (grant == GRANT_DCACHE);
	end

endmodule : line_arbiter

`default_nettype wire

// ==== verilog/eviction_write_buffer.sv ====
`default_nettype none

module eviction_write_buffer import mem_path_pkg::*; (
	input  wire logic      clk,
	input  wire logic      rst_n,
	// from the arbiter
	input  wire line_req_t arb_req,
	output line_rsp_t      arb_rsp,
	// toward the cacheline adaptor
	output line_req_t      mem_req,
	input  wire line_rsp_t mem_rsp
);

	typedef enum logic [1:0] {
		ST_PASS       = 2'b00,
		ST_LOCAL      = 2'b01,
		ST_WAIT_DRAIN = 2'b10,
		ST_DRAIN      = 2'b11
	} state_t;

	state_t state;

	// the one held dirty line
	logic  full;
	addr_t held_addr;
	line_t held_line;

	// bus was quiet last cycle too
	logic idle_q;

	logic      req_present;
	addr_t     req_line_addr;
	logic      read_hit;
	logic      read_miss;
	logic      capture;
	logic      drain_start;
	line_req_t drain_req;

	assign req_present   = arb_req.read | arb_req.write;
	assign req_line_addr = line_align(arb_req.address);

	// read of the held line, answered locally
	assign read_hit  = arb_req.read & full & (req_line_addr == held_addr);
	assign read_miss = arb_req.read & ~read_hit;

	// load the holding register
	// either straight into an empty buffer, or right as the old line finishes draining
	assign capture = arb_req.write &
		(((state == ST_PASS) & ~full) | ((state == ST_WAIT_DRAIN) & mem_rsp.resp));

	// arbiter leaves a one-cycle gap between grants
	// so two quiet cycles are needed before the bus is really free
	assign drain_start = full & ~req_present & idle_q;

	// held line written back as a full line
	assign drain_req = '{read: 1'b0, write: 1'b1, address: held_addr, wdata: held_line};

	// control state
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state  <= ST_PASS;
			full   <= 1'b0;
			idle_q <= 1'b0;
		end else begin
			idle_q <= ~req_present;
			case (state)
				ST_PASS: begin
					if (capture) begin
						full  <= 1'b1;
						state <= ST_LOCAL;
					end else if (arb_req.write) begin
						// buffer occupied, push the old line out first
						state <= ST_WAIT_DRAIN;
					end else if (read_hit) begin
						state <= ST_LOCAL;
					end else if (drain_start) begin
						state <= ST_DRAIN;
					end
				end
				ST_LOCAL: begin
					// single resp cycle
					state <= ST_PASS;
				end
				ST_WAIT_DRAIN: begin
					// old line out, new one already captured, full stays set
					if (mem_rsp.resp) begin
						state <= ST_LOCAL;
					end
				end
				ST_DRAIN: begin
					if (mem_rsp.resp) begin
						full  <= 1'b0;
						state <= ST_PASS;
					end
				end
				default: begin
					state <= ST_PASS;
				end
			endcase
		end
	end

	// held payload
	always_ff @(posedge clk) begin
		if (capture) begin
			held_addr <= req_line_addr;
			held_line <= arb_req.wdata;
		end
	end

	// request and response routing
	always_comb begin
		mem_req = '0;
		arb_rsp = '0;
		case (state)
			ST_PASS: begin
				// misses go to memory ahead of any drain
				if (read_miss) begin
					mem_req.read    = 1'b1;
					mem_req.address = req_line_addr;
					arb_rsp         = mem_rsp;
				end
			end
			ST_LOCAL: begin
				// rdata only matters for a read hit
				arb_rsp.resp  = 1'b1;
				arb_rsp.rdata = held_line;
			end
			ST_WAIT_DRAIN, ST_DRAIN: begin
				// requester waits, no resp forwarded
				mem_req = drain_req;
			end
			default: begin
				mem_req = '0;
			end
		endcase
	end

endmodule : eviction_write_buffer

`default_nettype wire

// ==== verilog/cacheline_adaptor.sv ====
`default_nettype none

module cacheline_adaptor import mem_path_pkg::*; (
	input  wire logic      clk,
	input  wire logic      rst_n,
	// line side
	input  wire line_req_t mem_req,
	output line_rsp_t      mem_rsp,
	// physical memory, four-beat bursts
	output logic           pmem_read,
	output logic           pmem_write,
	output addr_t          pmem_address,
	output beat_t          pmem_wdata,
	input  wire beat_t     pmem_rdata,
	input  wire logic      pmem_resp
);

	typedef enum logic [1:0] {
		AD_IDLE  = 2'b00,
		AD_BURST = 2'b01,
		AD_DONE  = 2'b10
	} state_t;

	state_t state;

	// latched request
	logic  is_write;
	addr_t addr_q;

	// shift register, beats leave and enter at opposite ends
	line_t line_q;

	beat_cnt_t beat_cnt;

	logic start;
	logic last_beat;

	assign start     = (state == AD_IDLE) & (mem_req.read | mem_req.write);
	assign last_beat = pmem_resp & (beat_cnt == LAST_BEAT);

	// control
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state    <= AD_IDLE;
			is_write <= 1'b0;
			beat_cnt <= '0;
		end else begin
			case (state)
				AD_IDLE: begin
					if (start) begin
						state    <= AD_BURST;
						is_write <= mem_req.write;
						beat_cnt <= '0;
					end
				end
				AD_BURST: begin
					// beats need not be back to back
					if (pmem_resp) begin
						beat_cnt <= beat_cnt + 1'b1;
						if (last_beat) begin
							state <= AD_DONE;
						end
					end
				end
				AD_DONE: begin
					// requester still holds its request this cycle
					state <= AD_IDLE;
				end
				default: begin
					state <= AD_IDLE;
				end
			endcase
		end
	end

	// datapath
	// lowest beat first in both directions
	always_ff @(posedge clk) begin
		if (start) begin
			addr_q <= line_align(mem_req.address);
			line_q <= mem_req.wdata;
		end else if ((state == AD_BURST) && pmem_resp) begin
			// read beats fill from the top, write beats drop off the bottom
			line_q <= {pmem_rdata, line_q[LINE_WIDTH-1:BEAT_WIDTH]};
		end
	end

	// strobes low outside the burst
	assign pmem_read    = (state == AD_BURST) & ~is_write;
	assign pmem_write   = (state == AD_BURST) & is_write;
	assign pmem_address = addr_q;
	assign pmem_wdata   = line_q[BEAT_WIDTH-1:0];

	// assembled line valid with the resp pulse
	always_comb begin
		mem_rsp.resp  = (state == AD_DONE);
		mem_rsp.rdata = line_q;
	end

endmodule : cacheline_adaptor

`default_nettype wire

// ==== verilog/mem_path.sv ====
`default_nettype none

module mem_path import mem_path_pkg::*; (
	input  wire logic      clk,
	input  wire logic      rst_n,
	// instruction cache port
	input  wire line_req_t icache_req,
	output line_rsp_t      icache_rsp,
	// data cache port
	input  wire line_req_t dcache_req,
	output line_rsp_t      dcache_rsp,
	// physical memory port
	output logic           pmem_read,
	output logic           pmem_write,
	output addr_t          pmem_address,
	output beat_t          pmem_wdata,
	input  wire beat_t     pmem_rdata,
	input  wire logic      pmem_resp
);

	// arbiter to write buffer
	line_req_t arb_req;
	line_rsp_t arb_rsp;

	// write buffer to adaptor
	line_req_t mem_req;
	line_rsp_t mem_rsp;

	line_arbiter arbiter_i (
		.clk,
		.rst_n,
		.icache_req,
		.icache_rsp,
		.dcache_req,
		.dcache_rsp,
		.arb_req,
		.arb_rsp
	);

	eviction_write_buffer buffer_i (
		.clk,
		.rst_n,
		.arb_req,
		.arb_rsp,
		.mem_req,
		.mem_rsp
	);

	cacheline_adaptor adaptor_i (
		.clk,
		.rst_n,
		.mem_req,
		.mem_rsp,
		.pmem_read,
		.pmem_write,
		.pmem_address,
		.pmem_wdata,
		.pmem_rdata,
		.pmem_resp
	);

endmodule : mem_path

`default_nettype wire

// ==== dv/pmem_model.sv ====
`default_nettype none

module pmem_model import mem_path_pkg::*; #(
	parameter int LATENCY = 6
) (
	input  wire logic  clk,
	input  wire logic  rst_n,
	input  wire logic  pmem_read,
	input  wire logic  pmem_write,
	input  wire addr_t pmem_address,
	input  wire beat_t pmem_wdata,
	output beat_t      pmem_rdata,
	output logic       pmem_resp
);
	timeunit 1ns;
	timeprecision 1ns;

	// one idle cycle is inserted before this beat
	localparam int GAP_BEAT = 2;

	// written lines only, everything else comes from the pattern
	line_t store [addr_t];

	// fill pattern, every word mixes the whole address
	function automatic line_t pattern_line(input addr_t a);
		line_t l;
		for (int w = 0; w < LINE_WIDTH / 32; w++) begin
			l[w*32 +: 32] = (a * 32'h9e37_79b1) ^ (a >> 3) ^ (32'(w) << 24) ^ 32'h5a5a_0000;
		end
		return l;
	endfunction

	// one full burst, read or write
	task automatic serve_burst();
		addr_t a;
		line_t l;
		logic  wr;
		a  = pmem_address;
		wr = pmem_write;
		l  = store.exists(a) ? store[a] : pattern_line(a);
		repeat (LATENCY) @(posedge clk);
		for (int b = 0; b < BEATS_PER_LINE; b++) begin
			// beats are not back to back
			if (b == GAP_BEAT) begin
				@(posedge clk);
				#10;
				pmem_resp = 1'b0;
			end
			@(posedge clk);
			#10;
			pmem_resp  = 1'b1;
			pmem_rdata = l[b*BEAT_WIDTH +: BEAT_WIDTH];
			// write beat is stable mid cycle
			@(negedge clk);
			if (wr) begin
				l[b*BEAT_WIDTH +: BEAT_WIDTH] = pmem_wdata;
			end
		end
		@(posedge clk);
		#10;
		pmem_resp = 1'b0;
		if (wr) begin
			store[a] = l;
		end
	endtask

	initial begin
		pmem_resp  = 1'b0;
		pmem_rdata = '0;
		forever begin
			@(negedge clk);
			if (rst_n && (pmem_read || pmem_write)) begin
				serve_burst();
			end
		end
	end

endmodule : pmem_model

`default_nettype wire

// ==== dv/mem_path_tb.sv ====
`default_nettype none

module mem_path_tb import mem_path_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ns;

	localparam int MEM_LATENCY = 6;
	localparam int unsigned SEED = 32'hd2db;
	localparam int RANDOM_REQS = 200;
	localparam int DIRECTED_REQS = 14;
	// drain of the held line plus the request's own burst
	localparam int ROUND_TRIP = 2 * (MEM_LATENCY + BEATS_PER_LINE + 3) + 4;
	localparam int TIMEOUT_CYCLES = (RANDOM_REQS + DIRECTED_REQS) * ROUND_TRIP * 4;

	logic      clk;
	logic      rst_n;
	line_req_t icache_req;
	line_rsp_t icache_rsp;
	line_req_t dcache_req;
	line_rsp_t dcache_rsp;
	logic      pmem_read;
	logic      pmem_write;
	addr_t     pmem_address;
	beat_t     pmem_wdata;
	beat_t     pmem_rdata;
	logic      pmem_resp;

	// last accepted writeback per line
	line_t shadow [addr_t];

	// outstanding requests as the monitors see them
	logic  i_pending;
	addr_t i_addr;
	logic  d_pending;
	logic  d_write;
	addr_t d_addr;
	line_t d_wdata;

	// pmem burst log in arrival order
	addr_t burst_addr_q[$];
	logic  burst_wr_q[$];
	line_t burst_line;
	int    beat_idx = 0;

	int unsigned cycle_count = 0;
	int unsigned i_resp_cycle;
	int unsigned d_resp_cycle;
	int write_count = 0;
	int drain_count = 0;
	int checks = 0;
	int errors = 0;
	int checks_at_start;
	int errors_at_start;

	mem_path dut_i (
		.clk,
		.rst_n,
		.icache_req,
		.icache_rsp,
		.dcache_req,
		.dcache_rsp,
		.pmem_read,
		.pmem_write,
		.pmem_address,
		.pmem_wdata,
		.pmem_rdata,
		.pmem_resp
	);

	pmem_model #(.LATENCY(MEM_LATENCY)) mem_i (
		.clk,
		.rst_n,
		.pmem_read,
		.pmem_write,
		.pmem_address,
		.pmem_wdata,
		.pmem_rdata,
		.pmem_resp
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) cycle_count <= cycle_count + 1;

	// hang guard
	initial begin
		wait (cycle_count >= TIMEOUT_CYCLES);
		$display("timeout: the memory path stopped answering after %0d cycles", cycle_count);
		$display("Checks failed");
		$finish;
	end

	// latest writeback or else the initial memory contents
	function automatic line_t expected_line(input addr_t a);
		if (shadow.exists(a)) begin
			return shadow[a];
		end
		return mem_i.pattern_line(a);
	endfunction

	task automatic check_line(input string name, input line_t got, input line_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_addr(input string name, input addr_t got, input addr_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic report_error(input string what);
		checks++;
		errors++;
		$display("ERROR: %s", what);
	endtask

	// cache side responses
	always @(negedge clk) begin
		if (rst_n && icache_rsp.resp) begin
			i_resp_cycle = cycle_count;
			if (!i_pending) begin
				report_error("icache resp arrived with no icache request pending");
			end else begin
				check_line("icache_rsp.rdata", icache_rsp.rdata, expected_line(i_addr));
			end
		end
		if (rst_n && dcache_rsp.resp) begin
			d_resp_cycle = cycle_count;
			if (!d_pending) begin
				report_error("dcache resp arrived with no dcache request pending");
			end else if (d_write) begin
				// accepted writeback becomes visible to later reads
				shadow[d_addr] = d_wdata;
				write_count++;
			end else begin
				check_line("dcache_rsp.rdata", dcache_rsp.rdata, expected_line(d_addr));
			end
		end
	end

	// rebuild pmem bursts and compare write bursts with the shadow
	always @(negedge clk) begin
		if (rst_n && pmem_resp && (pmem_read || pmem_write)) begin
			burst_line[beat_idx*BEAT_WIDTH +: BEAT_WIDTH] = pmem_wdata;
			if (beat_idx == BEATS_PER_LINE - 1) begin
				burst_addr_q.push_back(pmem_address);
				burst_wr_q.push_back(pmem_write);
				if (pmem_write) begin
					check_line("pmem_wdata", burst_line, expected_line(pmem_address));
					drain_count++;
				end
				beat_idx = 0;
			end else begin
				beat_idx++;
			end
		end
	end

	// the two caches use separate regions and never share a line
	function automatic addr_t icache_line(input int i);
		return 32'h0001_0000 + 32'(i) * 32;
	endfunction

	function automatic addr_t dcache_line(input int i);
		return 32'h0002_0000 + 32'(i) * 32;
	endfunction

	function automatic line_t random_line();
		line_t l;
		for (int w = 0; w < LINE_WIDTH / 32; w++) begin
			l[w*32 +: 32] = $urandom;
		end
		return l;
	endfunction

	// all drivers start and end 10 ns after a rising edge
	task automatic icache_read(input addr_t a);
		i_addr = a;
		i_pending = 1'b1;
		icache_req = '0;
		icache_req.read = 1'b1;
		icache_req.address = a;
		@(negedge clk);
		while (!icache_rsp.resp) @(negedge clk);
		@(posedge clk);
		#10;
		icache_req = '0;
		i_pending = 1'b0;
	endtask

	task automatic dcache_access(input logic wr, input addr_t a, input line_t d);
		d_addr = a;
		d_write = wr;
		d_wdata = d;
		d_pending = 1'b1;
		dcache_req = '0;
		dcache_req.read = ~wr;
		dcache_req.write = wr;
		dcache_req.address = a;
		dcache_req.wdata = wr ? d : '0;
		@(negedge clk);
		while (!dcache_rsp.resp) @(negedge clk);
		@(posedge clk);
		#10;
		dcache_req = '0;
		d_pending = 1'b0;
	endtask

	task automatic idle_cycles(input int n);
		if (n > 0) begin
			repeat (n) @(posedge clk);
			#10;
		end
	endtask

	// every accepted writeback has left the buffer
	task automatic wait_drained();
		while (drain_count != write_count) @(negedge clk);
		@(posedge clk);
		#10;
	endtask

	task automatic begin_test();
		checks_at_start = checks;
		errors_at_start = errors;
	endtask

	task automatic end_test(input string name);
		$display("test %s: %0d checks, %0d errors", name, checks - checks_at_start,
			errors - errors_at_start);
	endtask

	task automatic icache_reads_alone();
		addr_t a;
		int n0;
		begin_test();
		for (int i = 0; i < 4; i++) begin
			a = icache_line(i);
			n0 = burst_addr_q.size();
			icache_read(a);
			if (burst_addr_q.size() != n0 + 1) begin
				report_error("icache read did not cause exactly one pmem burst");
			end else begin
				check_addr("pmem_address", burst_addr_q[n0], a);
				if (burst_wr_q[n0]) begin
					report_error("pmem burst for an icache read was a write");
				end
			end
		end
		end_test("1 icache reads");
	endtask

	task automatic writeback_read_hit();
		int n0;
		begin_test();
		dcache_access(1'b1, dcache_line(0), random_line());
		n0 = burst_addr_q.size();
		dcache_access(1'b0, dcache_line(0), '0);
		if (burst_addr_q.size() != n0) begin
			report_error("read of the held line went out to pmem");
		end
		end_test("2 writeback then read hit");
	endtask

	task automatic miss_before_drain();
		int n0;
		begin_test();
		// line 0 is still held so this write waits for its drain
		dcache_access(1'b1, dcache_line(1), random_line());
		n0 = burst_addr_q.size();
		dcache_access(1'b0, dcache_line(2), '0);
		wait_drained();
		if (burst_addr_q.size() < n0 + 2) begin
			report_error("expected a read burst and a write burst after the miss");
		end else begin
			check_addr("pmem_address", burst_addr_q[n0], dcache_line(2));
			check_addr("pmem_address", burst_addr_q[n0 + 1], dcache_line(1));
			if (burst_wr_q[n0] || !burst_wr_q[n0 + 1]) begin
				report_error("held line was drained before the read miss was served");
			end
		end
		end_test("3 read miss ahead of drain");
	endtask

	task automatic drain_all_writebacks();
		int n0;
		begin_test();
		// line 3 written twice and the older copy drains first
		dcache_access(1'b1, dcache_line(3), random_line());
		dcache_access(1'b1, dcache_line(4), random_line());
		dcache_access(1'b1, dcache_line(3), random_line());
		wait_drained();
		n0 = burst_addr_q.size();
		dcache_access(1'b0, dcache_line(3), '0);
		if (burst_addr_q.size() != n0 + 1) begin
			report_error("read after drain did not fetch the line from pmem");
		end
		end_test("4 writebacks drained");
	endtask

	task automatic tie_goes_to_dcache();
		begin_test();
		fork
			icache_read(icache_line(5));
			dcache_access(1'b0, dcache_line(2), '0);
		join
		if (!(d_resp_cycle < i_resp_cycle)) begin
			report_error("icache was served before dcache on a same-cycle request");
		end
		end_test("5 tie goes to dcache");
	endtask

	task automatic random_mix();
		begin_test();
		fork
			for (int i = 0; i < RANDOM_REQS / 2; i++) begin
				icache_read(icache_line($urandom_range(7, 0)));
				idle_cycles($urandom_range(3, 0));
			end
			for (int i = 0; i < RANDOM_REQS / 2; i++) begin
				// small pool keeps hits in the buffer likely
				dcache_access(1'($urandom_range(1, 0)), dcache_line($urandom_range(5, 0)),
					random_line());
				idle_cycles($urandom_range(3, 0));
			end
		join
		wait_drained();
		end_test("6 random mix");
	endtask

	initial begin
		void'($urandom(SEED));
		rst_n = 1'b0;
		icache_req = '0;
		dcache_req = '0;
		i_pending = 1'b0;
		d_pending = 1'b0;
		repeat (8) @(posedge clk);
		#10;
		rst_n = 1'b1;
		@(posedge clk);
		#10;
		icache_reads_alone();
		writeback_read_hit();
		miss_before_drain();
		drain_all_writebacks();
		tie_goes_to_dcache();
		random_mix();
		$display("summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule : mem_path_tb

`default_nettype wire

// ==== mem_path.f ====
verilog/mem_path_pkg.sv
verilog/line_arbiter.sv
verilog/eviction_write_buffer.sv
verilog/cacheline_adaptor.sv
verilog/mem_path.sv
dv/pmem_model.sv
dv/mem_path_tb.sv
